// File: include/cdb_settings.svh
`ifndef CDB_SETTINGS_SVH
`define CDB_SETTINGS_SVH

// data and pc width
`define CDB_XLEN 32

// physical register index width
`define CDB_PRF_LEN 6

// reorder buffer index width
`define CDB_ROB_LEN 5

// per-source result queue depths
`define CDB_ALU_QUEUE_DEPTH 4
`define CDB_MUL_QUEUE_DEPTH 4
`define CDB_BR_QUEUE_DEPTH 4

`endif

// File: src/cdb_pkg.sv
`include "cdb_settings.svh"

package cdb_pkg;

    // 75-bit common write-back payload
    typedef struct packed {
        logic [`CDB_XLEN-1:0]    value;
        logic [`CDB_PRF_LEN-1:0] prf_idx;
        logic [`CDB_ROB_LEN-1:0] rob_idx;
        logic [`CDB_XLEN-1:0]    pc;
    } wb_result_t;

    // 113-bit branch unit payload
    typedef struct packed {
        wb_result_t           wb;
        // resolved outcome
        logic                 direction;
        logic [`CDB_XLEN-1:0] target_pc;
        logic                 mis_pred;
        // branch kind
        logic                 cond_branch;
        logic                 uncond_branch;
        // what the predictors said at fetch
        logic                 local_pred;
        logic                 global_pred;
    } br_result_t;

    // source owning the bus or SRC_NONE when idle
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_ALU  = 2'd1,
        SRC_MUL  = 2'd2,
        SRC_BR   = 2'd3
    } cdb_source_e;

endpackage

// File: src/cdb_result_queue.sv
`timescale 1ns/10ps

module cdb_result_queue #(
    parameter type PAYLOAD_T = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     flush,
    // write-back side
    input  logic     valid,
    input  PAYLOAD_T data,
    output logic     ready,
    // arbitration side
    input  logic     pop,
    output logic     avail,
    output PAYLOAD_T head
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    PAYLOAD_T         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic empty;
    logic push;
    logic store;
    logic drain;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);

    // space left without look-ahead on pop
    assign ready = (count < CNT_W'(DEPTH));

    // a request exists if something is stored or arriving now
    assign avail = ~empty | valid;

    // empty queue shows the incoming result so it can bypass storage
    assign head = empty ? data : mem[rd_ptr];

    // inputs of a flush cycle are dropped
    assign push = valid & ready & ~flush;

    // a bypassed result is never written
    assign store = push & ~(empty & pop);
    assign drain = pop & ~empty;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (store) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (drain) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(store) - CNT_W'(drain);
        end
    end

    // storage array
    always_ff @(posedge clock) begin
        if (store) begin
            mem[wr_ptr] <= data;
        end
    end

endmodule

// File: src/cdb_control.sv
`timescale 1ns/10ps

module cdb_control (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                commit_mis_pred,
    // requests from the queues
    input  logic                alu_avail,
    input  logic                mul_avail,
    input  logic                br_avail,
    // queue advance is one-hot at most
    output logic                alu_pop,
    output logic                mul_pop,
    output logic                br_pop,
    output logic                flush,
    output cdb_pkg::cdb_source_e grant
);

    logic mis_pred_q;

    // previous commit_mis_pred for edge detect
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mis_pred_q <= 1'b0;
        end else begin
            mis_pred_q <= commit_mis_pred;
        end
    end

    // single-cycle flush on the first cycle of a commit misprediction
    assign flush = commit_mis_pred & ~mis_pred_q;

    // fixed priority of alu over mul over branch
    always_comb begin
        grant = cdb_pkg::SRC_NONE;
        if (!commit_mis_pred) begin
            if (alu_avail) begin
                grant = cdb_pkg::SRC_ALU;
            end else if (mul_avail) begin
                grant = cdb_pkg::SRC_MUL;
            end else if (br_avail) begin
                grant = cdb_pkg::SRC_BR;
            end
        end
    end

    // winner's queue moves on
    assign alu_pop = (grant == cdb_pkg::SRC_ALU);
    assign mul_pop = (grant == cdb_pkg::SRC_MUL);
    assign br_pop  = (grant == cdb_pkg::SRC_BR);

endmodule

// File: src/cdb_broadcast_reg.sv
`timescale 1ns/10ps
`include "cdb_settings.svh"

module cdb_broadcast_reg (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        flush,
    input  cdb_pkg::cdb_source_e        grant,
    // queue heads
    input  cdb_pkg::wb_result_t         alu_head,
    input  cdb_pkg::wb_result_t         mul_head,
    input  cdb_pkg::br_result_t         br_head,
    // common data bus
    output logic                        cdb_valid,
    output logic [`CDB_XLEN-1:0]        cdb_value,
    output logic [`CDB_PRF_LEN-1:0]     cdb_prf_idx,
    output logic [`CDB_ROB_LEN-1:0]     cdb_rob_idx,
    output logic [`CDB_XLEN-1:0]        cdb_pc,
    output cdb_pkg::cdb_source_e        cdb_source,
    // branch outcome
    output logic                        cdb_br_direction,
    output logic [`CDB_XLEN-1:0]        cdb_br_target_pc,
    output logic                        cdb_mis_pred,
    output logic                        cdb_local_pred,
    output logic                        cdb_global_pred
);

    cdb_pkg::wb_result_t sel_wb;
    logic                sel_br;

    assign sel_br = (grant == cdb_pkg::SRC_BR);

    // pick the granted payload
    always_comb begin
        case (grant)
            cdb_pkg::SRC_ALU: sel_wb = alu_head;
            cdb_pkg::SRC_MUL: sel_wb = mul_head;
            cdb_pkg::SRC_BR:  sel_wb = br_head.wb;
            default:          sel_wb = '0;
        endcase
    end

    // bus control fields
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cdb_valid    <= 1'b0;
            cdb_source   <= cdb_pkg::SRC_NONE;
            cdb_mis_pred <= 1'b0;
        end else if (flush) begin
            cdb_valid    <= 1'b0;
            cdb_source   <= cdb_pkg::SRC_NONE;
            cdb_mis_pred <= 1'b0;
        end else begin
            cdb_valid    <= (grant != cdb_pkg::SRC_NONE);
            cdb_source   <= grant;
            // only a branch broadcast may signal a misprediction
            cdb_mis_pred <= sel_br & br_head.mis_pred;
        end
    end

    // payload holds while idle
    always_ff @(posedge clock) begin
        if (!flush && grant != cdb_pkg::SRC_NONE) begin
            cdb_value   <= sel_wb.value;
            cdb_prf_idx <= sel_wb.prf_idx;
            cdb_rob_idx <= sel_wb.rob_idx;
            cdb_pc      <= sel_wb.pc;
        end
    end

    // branch fields only change on branch broadcasts
    always_ff @(posedge clock) begin
        if (!flush && sel_br) begin
            cdb_br_direction <= br_head.direction;
            cdb_br_target_pc <= br_head.target_pc;
            cdb_local_pred   <= br_head.local_pred;
            cdb_global_pred  <= br_head.global_pred;
        end
    end

endmodule

// File: src/cdb_top.sv
`timescale 1ns/10ps
`include "cdb_settings.svh"

module cdb_top (
    input  logic                        clock,
    input  logic                        arst_n,
    input  logic                        commit_mis_pred,
    // alu write-back
    input  logic                        alu_valid,
    input  logic [`CDB_XLEN-1:0]        alu_value,
    input  logic [`CDB_PRF_LEN-1:0]     alu_prf_idx,
    input  logic [`CDB_ROB_LEN-1:0]     alu_rob_idx,
    input  logic [`CDB_XLEN-1:0]        alu_pc,
    output logic                        alu_ready,
    // multiplier write-back
    input  logic                        mul_valid,
    input  logic [`CDB_XLEN-1:0]        mul_value,
    input  logic [`CDB_PRF_LEN-1:0]     mul_prf_idx,
    input  logic [`CDB_ROB_LEN-1:0]     mul_rob_idx,
    input  logic [`CDB_XLEN-1:0]        mul_pc,
    output logic                        mul_ready,
    // branch unit write-back
    input  logic                        br_valid,
    input  logic [`CDB_XLEN-1:0]        br_value,
    input  logic [`CDB_PRF_LEN-1:0]     br_prf_idx,
    input  logic [`CDB_ROB_LEN-1:0]     br_rob_idx,
    input  logic [`CDB_XLEN-1:0]        br_pc,
    input  logic                        br_direction,
    input  logic [`CDB_XLEN-1:0]        br_target_pc,
    input  logic                        br_mis_pred,
    input  logic                        br_cond_branch,
    input  logic                        br_uncond_branch,
    input  logic                        br_local_pred,
    input  logic                        br_global_pred,
    output logic                        br_ready,
    // common data bus
    output logic                        cdb_valid,
    output logic [`CDB_XLEN-1:0]        cdb_value,
    output logic [`CDB_PRF_LEN-1:0]     cdb_prf_idx,
    output logic [`CDB_ROB_LEN-1:0]     cdb_rob_idx,
    output logic [`CDB_XLEN-1:0]        cdb_pc,
    output cdb_pkg::cdb_source_e        cdb_source,
    output logic                        cdb_br_direction,
    output logic [`CDB_XLEN-1:0]        cdb_br_target_pc,
    output logic                        cdb_mis_pred,
    output logic                        cdb_local_pred,
    output logic                        cdb_global_pred
);

    cdb_pkg::wb_result_t  alu_data;
    cdb_pkg::wb_result_t  mul_data;
    cdb_pkg::br_result_t  br_data;
    cdb_pkg::wb_result_t  alu_head;
    cdb_pkg::wb_result_t  mul_head;
    cdb_pkg::br_result_t  br_head;
    cdb_pkg::cdb_source_e grant;

    logic alu_avail;
    logic mul_avail;
    logic br_avail;
    logic alu_pop;
    logic mul_pop;
    logic br_pop;
    logic flush;

    // pack unit fields into queue payloads
    assign alu_data = '{value: alu_value, prf_idx: alu_prf_idx,
                        rob_idx: alu_rob_idx, pc: alu_pc};
    assign mul_data = '{value: mul_value, prf_idx: mul_prf_idx,
                        rob_idx: mul_rob_idx, pc: mul_pc};

    assign br_data.wb            = '{value: br_value, prf_idx: br_prf_idx,
                                     rob_idx: br_rob_idx, pc: br_pc};
    assign br_data.direction     = br_direction;
    assign br_data.target_pc     = br_target_pc;
    assign br_data.mis_pred      = br_mis_pred;
    assign br_data.cond_branch   = br_cond_branch;
    assign br_data.uncond_branch = br_uncond_branch;
    assign br_data.local_pred    = br_local_pred;
    assign br_data.global_pred   = br_global_pred;

    cdb_result_queue #(
        .PAYLOAD_T (cdb_pkg::wb_result_t),
        .DEPTH     (`CDB_ALU_QUEUE_DEPTH)
    ) alu_queue_i (
        .clock  (clock),
        .arst_n (arst_n),
        .flush  (flush),
        .valid  (alu_valid),
        .data   (alu_data),
        .ready  (alu_ready),
        .pop    (alu_pop),
        .avail  (alu_avail),
        .head   (alu_head)
    );

    cdb_result_queue #(
        .PAYLOAD_T (cdb_pkg::wb_result_t),
        .DEPTH     (`CDB_MUL_QUEUE_DEPTH)
    ) mul_queue_i (
        .clock  (clock),
        .arst_n (arst_n),
        .flush  (flush),
        .valid  (mul_valid),
        .data   (mul_data),
        .ready  (mul_ready),
        .pop    (mul_pop),
        .avail  (mul_avail),
        .head   (mul_head)
    );

    cdb_result_queue #(
        .PAYLOAD_T (cdb_pkg::br_result_t),
        .DEPTH     (`CDB_BR_QUEUE_DEPTH)
    ) br_queue_i (
        .clock  (clock),
        .arst_n (arst_n),
        .flush  (flush),
        .valid  (br_valid),
        .data   (br_data),
        .ready  (br_ready),
        .pop    (br_pop),
        .avail  (br_avail),
        .head   (br_head)
    );

    cdb_control control_i (
        .clock           (clock),
        .arst_n          (arst_n),
        .commit_mis_pred (commit_mis_pred),
        .alu_avail       (alu_avail),
        .mul_avail       (mul_avail),
        .br_avail        (br_avail),
        .alu_pop         (alu_pop),
        .mul_pop         (mul_pop),
        .br_pop          (br_pop),
        .flush           (flush),
        .grant           (grant)
    );

    cdb_broadcast_reg bcast_i (
        .clock            (clock),
        .arst_n           (arst_n),
        .flush            (flush),
        .grant            (grant),
        .alu_head         (alu_head),
        .mul_head         (mul_head),
        .br_head          (br_head),
        .cdb_valid        (cdb_valid),
        .cdb_value        (cdb_value),
        .cdb_prf_idx      (cdb_prf_idx),
        .cdb_rob_idx      (cdb_rob_idx),
        .cdb_pc           (cdb_pc),
        .cdb_source       (cdb_source),
        .cdb_br_direction (cdb_br_direction),
        .cdb_br_target_pc (cdb_br_target_pc),
        .cdb_mis_pred     (cdb_mis_pred),
        .cdb_local_pred   (cdb_local_pred),
        .cdb_global_pred  (cdb_global_pred)
    );

endmodule

// File: dv/cdb_asserts.sv
`timescale 1ns/10ps

module cdb_asserts (
    input logic clock,
    input logic arst_n,
    input logic flush,
    input logic alu_pop,
    input logic mul_pop,
    input logic br_pop,
    input logic alu_valid,
    input logic alu_ready,
    input logic mul_valid,
    input logic mul_ready,
    input logic br_valid,
    input logic br_ready,
    input logic cdb_valid
);

    // number of assertion failures so far
    int fail_count = 0;

    // at most one queue wins the bus per cycle and every win is broadcast
    grant_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0({alu_pop, mul_pop, br_pop}) &&
        (cdb_valid == $past(alu_pop | mul_pop | br_pop)))
        else begin
            $error("queue pops not one-hot or not matched by a broadcast");
            fail_count++;
        end

    // units must hold back while their queue is full
    alu_no_overrun: assert property (@(posedge clock) disable iff (!arst_n)
        alu_valid |-> alu_ready)
        else begin
            $error("alu result offered while its queue was full");
            fail_count++;
        end

    mul_no_overrun: assert property (@(posedge clock) disable iff (!arst_n)
        mul_valid |-> mul_ready)
        else begin
            $error("multiplier result offered while its queue was full");
            fail_count++;
        end

    br_no_overrun: assert property (@(posedge clock) disable iff (!arst_n)
        br_valid |-> br_ready)
        else begin
            $error("branch result offered while its queue was full");
            fail_count++;
        end

    // a flush cancels the broadcast
    flush_clears_bus: assert property (@(posedge clock) disable iff (!arst_n)
        flush |=> !cdb_valid)
        else begin
            $error("bus still valid in the cycle after a flush");
            fail_count++;
        end

endmodule

bind cdb_top cdb_asserts asserts_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .flush     (flush),
    .alu_pop   (alu_pop),
    .mul_pop   (mul_pop),
    .br_pop    (br_pop),
    .alu_valid (alu_valid),
    .alu_ready (alu_ready),
    .mul_valid (mul_valid),
    .mul_ready (mul_ready),
    .br_valid  (br_valid),
    .br_ready  (br_ready),
    .cdb_valid (cdb_valid)
);

// File: dv/cdb_tb.sv
`timescale 1ns/10ps
`include "cdb_settings.svh"

module cdb_tb;

    // all tests plus drains take about 300 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                    clock;
    logic                    arst_n;
    logic                    commit_mis_pred;
    logic                    alu_valid;
    logic                    mul_valid;
    logic                    br_valid;
    logic                    alu_ready;
    logic                    mul_ready;
    logic                    br_ready;
    cdb_pkg::wb_result_t     alu_in;
    cdb_pkg::wb_result_t     mul_in;
    cdb_pkg::br_result_t     br_in;
    logic                    cdb_valid;
    logic [`CDB_XLEN-1:0]    cdb_value;
    logic [`CDB_PRF_LEN-1:0] cdb_prf_idx;
    logic [`CDB_ROB_LEN-1:0] cdb_rob_idx;
    logic [`CDB_XLEN-1:0]    cdb_pc;
    cdb_pkg::cdb_source_e    cdb_source;
    logic                    cdb_br_direction;
    logic [`CDB_XLEN-1:0]    cdb_br_target_pc;
    logic                    cdb_mis_pred;
    logic                    cdb_local_pred;
    logic                    cdb_global_pred;

    int    err_count;
    int    check_count;
    int    test_count;
    int    cycle_count;
    int    errors_before;
    string test_name;

    // accepted results per source in arrival order
    cdb_pkg::wb_result_t alu_exp[$];
    cdb_pkg::wb_result_t mul_exp[$];
    cdb_pkg::br_result_t br_exp[$];

    cdb_top dut_i (
        .*,
        .alu_value        (alu_in.value),
        .alu_prf_idx      (alu_in.prf_idx),
        .alu_rob_idx      (alu_in.rob_idx),
        .alu_pc           (alu_in.pc),
        .mul_value        (mul_in.value),
        .mul_prf_idx      (mul_in.prf_idx),
        .mul_rob_idx      (mul_in.rob_idx),
        .mul_pc           (mul_in.pc),
        .br_value         (br_in.wb.value),
        .br_prf_idx       (br_in.wb.prf_idx),
        .br_rob_idx       (br_in.wb.rob_idx),
        .br_pc            (br_in.wb.pc),
        .br_direction     (br_in.direction),
        .br_target_pc     (br_in.target_pc),
        .br_mis_pred      (br_in.mis_pred),
        .br_cond_branch   (br_in.cond_branch),
        .br_uncond_branch (br_in.uncond_branch),
        .br_local_pred    (br_in.local_pred),
        .br_global_pred   (br_in.global_pred)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // own checks plus failures of the bound assertions
    function automatic int total_errors();
        return err_count + dut_i.asserts_i.fail_count;
    endfunction

    task automatic check_value(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (exp === act) else begin
            $display("ERROR %s %s: expected %h actual %h", test_name, field, exp, act);
            err_count++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("%s: %s", test_name, what);
            err_count++;
        end
    endtask

    task automatic compare_wb(input cdb_pkg::wb_result_t exp);
        check_value("value", exp.value, cdb_value);
        check_value("prf_idx", exp.prf_idx, cdb_prf_idx);
        check_value("rob_idx", exp.rob_idx, cdb_rob_idx);
        check_value("pc", exp.pc, cdb_pc);
    endtask

    task automatic compare_br(input cdb_pkg::br_result_t exp);
        compare_wb(exp.wb);
        check_value("direction", exp.direction, cdb_br_direction);
        check_value("target_pc", exp.target_pc, cdb_br_target_pc);
        check_value("mis_pred", exp.mis_pred, cdb_mis_pred);
        check_value("local_pred", exp.local_pred, cdb_local_pred);
        check_value("global_pred", exp.global_pred, cdb_global_pred);
    endtask

    // scoreboard reads the bus before the edge updates it
    always @(posedge clock) begin
        if (arst_n && cdb_valid) begin
            case (cdb_source)
                cdb_pkg::SRC_ALU: begin
                    check_true(alu_exp.size() > 0, "alu broadcast with no alu result pending");
                    if (alu_exp.size() > 0) begin
                        compare_wb(alu_exp.pop_front());
                        check_value("mis_pred", 0, cdb_mis_pred);
                    end
                end
                cdb_pkg::SRC_MUL: begin
                    check_true(mul_exp.size() > 0, "mul broadcast with no mul result pending");
                    if (mul_exp.size() > 0) begin
                        compare_wb(mul_exp.pop_front());
                        check_value("mis_pred", 0, cdb_mis_pred);
                    end
                end
                cdb_pkg::SRC_BR: begin
                    check_true(br_exp.size() > 0, "branch broadcast with no branch pending");
                    if (br_exp.size() > 0) begin
                        compare_br(br_exp.pop_front());
                    end
                end
                default: begin
                    check_true(1'b0, "bus valid without a source");
                end
            endcase
        end
    end

    function automatic logic [127:0] random_bits();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic cdb_pkg::wb_result_t random_wb();
        logic [127:0] bits;
        bits = random_bits();
        return bits[$bits(cdb_pkg::wb_result_t)-1:0];
    endfunction

    function automatic cdb_pkg::br_result_t random_br();
        logic [127:0] bits;
        bits = random_bits();
        return bits[$bits(cdb_pkg::br_result_t)-1:0];
    endfunction

    // move to the falling edge and drop all valids
    task automatic next_cycle();
        @(negedge clock);
        alu_valid       = 1'b0;
        mul_valid       = 1'b0;
        br_valid        = 1'b0;
        commit_mis_pred = 1'b0;
    endtask

    // offers only while the queue has room
    task automatic offer_wb(input cdb_pkg::cdb_source_e src, input cdb_pkg::wb_result_t r);
        if (src == cdb_pkg::SRC_ALU && alu_ready) begin
            alu_in    = r;
            alu_valid = 1'b1;
            if (!commit_mis_pred) begin
                alu_exp.push_back(r);
            end
        end else if (src == cdb_pkg::SRC_MUL && mul_ready) begin
            mul_in    = r;
            mul_valid = 1'b1;
            if (!commit_mis_pred) begin
                mul_exp.push_back(r);
            end
        end
    endtask

    task automatic offer_br(input cdb_pkg::br_result_t r);
        if (br_ready) begin
            br_in    = r;
            br_valid = 1'b1;
            if (!commit_mis_pred) begin
                br_exp.push_back(r);
            end
        end
    endtask

    task automatic wait_drain();
        while (alu_exp.size() + mul_exp.size() + br_exp.size() > 0) begin
            next_cycle();
        end
        // idle time to catch duplicate broadcasts
        repeat (3) next_cycle();
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = total_errors();
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s done, %0d errors", test_name, total_errors() - errors_before);
    endtask

    task automatic single_alu_test();
        cdb_pkg::wb_result_t r;
        r = random_wb();
        check_value("cdb_valid", 0, cdb_valid);
        check_value("cdb_source", cdb_pkg::SRC_NONE, cdb_source);
        check_value("cdb_mis_pred", 0, cdb_mis_pred);
        check_value("ready", 3'b111, {alu_ready, mul_ready, br_ready});
        next_cycle();
        offer_wb(cdb_pkg::SRC_ALU, r);
        next_cycle();
        check_value("cdb_valid", 1, cdb_valid);
        check_value("cdb_source", cdb_pkg::SRC_ALU, cdb_source);
        check_value("rob_idx", r.rob_idx, cdb_rob_idx);
        wait_drain();
    endtask

    task automatic priority_test();
        cdb_pkg::cdb_source_e order[3];
        order = '{cdb_pkg::SRC_ALU, cdb_pkg::SRC_MUL, cdb_pkg::SRC_BR};
        next_cycle();
        offer_wb(cdb_pkg::SRC_ALU, random_wb());
        offer_wb(cdb_pkg::SRC_MUL, random_wb());
        offer_br(random_br());
        foreach (order[i]) begin
            next_cycle();
            check_value("cdb_valid", 1, cdb_valid);
            check_value("cdb_source", order[i], cdb_source);
        end
        wait_drain();
    endtask

    task automatic backpressure_test();
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            offer_wb(cdb_pkg::SRC_ALU, random_wb());
            if (i < 4) begin
                check_value("mul_ready", 1, mul_ready);
                offer_wb(cdb_pkg::SRC_MUL, random_wb());
            end else begin
                // alu wins every cycle, so four multiplier results fill the queue
                check_value("mul_ready", 0, mul_ready);
            end
        end
        wait_drain();
    endtask

    task automatic branch_test();
        cdb_pkg::br_result_t b;
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            b = random_br();
            // last branch mispredicts so the alu broadcast behind it must clear the flag
            if (i == 3) begin
                b.mis_pred = 1'b1;
            end
            offer_br(b);
        end
        next_cycle();
        offer_wb(cdb_pkg::SRC_ALU, random_wb());
        check_value("cdb_mis_pred", 1, cdb_mis_pred);
        next_cycle();
        check_value("cdb_source", cdb_pkg::SRC_ALU, cdb_source);
        check_value("cdb_mis_pred", 0, cdb_mis_pred);
        wait_drain();
    endtask

    task automatic flush_test();
        // the alu queue stays empty while it wins and the other two fill up
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            offer_wb(cdb_pkg::SRC_ALU, random_wb());
            offer_wb(cdb_pkg::SRC_MUL, random_wb());
            offer_br(random_br());
        end
        next_cycle();
        commit_mis_pred = 1'b1;
        offer_wb(cdb_pkg::SRC_ALU, random_wb());
        next_cycle();
        alu_exp.delete();
        mul_exp.delete();
        br_exp.delete();
        check_value("cdb_valid", 0, cdb_valid);
        check_value("ready", 3'b111, {alu_ready, mul_ready, br_ready});
        repeat (6) next_cycle();
    endtask

    task automatic random_stream_test();
        for (int i = 0; i < 200; i++) begin
            next_cycle();
            if ($urandom_range(99, 0) < 40) begin
                offer_wb(cdb_pkg::SRC_ALU, random_wb());
            end
            if ($urandom_range(99, 0) < 40) begin
                offer_wb(cdb_pkg::SRC_MUL, random_wb());
            end
            if ($urandom_range(99, 0) < 40) begin
                offer_br(random_br());
            end
        end
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h283a));
        err_count       = 0;
        check_count     = 0;
        test_count      = 0;
        cycle_count     = 0;
        test_name       = "reset";
        arst_n          = 1'b0;
        commit_mis_pred = 1'b0;
        alu_valid       = 1'b0;
        mul_valid       = 1'b0;
        br_valid        = 1'b0;
        alu_in          = '0;
        mul_in          = '0;
        br_in           = '0;
        repeat (10) @(negedge clock);
        arst_n = 1'b1;

        begin_test("single_alu");
        single_alu_test();
        end_test();
        begin_test("priority");
        priority_test();
        end_test();
        begin_test("backpressure");
        backpressure_test();
        end_test();
        begin_test("branch_fields");
        branch_test();
        end_test();
        begin_test("flush");
        flush_test();
        end_test();
        begin_test("random_stream");
        random_stream_test();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, total_errors());
        if (total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: cdb_subsys.f
+incdir+include
src/cdb_pkg.sv
src/cdb_result_queue.sv
src/cdb_control.sv
src/cdb_broadcast_reg.sv
src/cdb_top.sv
dv/cdb_asserts.sv
dv/cdb_tb.sv
